// ==== sim/id_input.dat ====
// inst exc plv fwd_en fwd_addr fwd_data aluop alusel wen waddr r1en r1addr r2en r2addr
// imm csr_rd csr_wr ex2 cause2 (ex2 and cause2 are slot 2 of the exception vector)
// Register-register ops
00101483 00 0 0 0000 00000000 01 3 1 03 1 04 1 05 00000000 0 0 0 00
001120e6 3b 0 0 0000 00000000 02 3 1 06 1 07 1 08 00000000 0 0 0 00
00128c41 00 0 0 0000 00000000 04 3 1 01 1 02 1 03 00000000 0 0 0 00
00142d49 04 0 0 0000 00000000 05 1 1 09 1 0a 1 0b 00000000 0 0 0 00
0015b9ac 00 0 0 0000 00000000 08 1 1 0c 1 0d 1 0e 00000000 0 0 0 00
0018460f 20 0 0 0000 00000000 0b 2 1 0f 1 10 1 11 00000000 0 0 0 00
// Immediate ops
02bffca4 00 0 0 0000 00000000 0e 3 1 04 1 05 0 1f ffffffff 0 0 0 00
036000e6 00 0 0 0000 00000000 0f 1 1 06 1 07 0 00 00000800 0 0 0 00
021ffd28 00 0 0 0000 00000000 0c 3 1 08 1 09 0 1f 000007ff 0 0 0 00
03eaf041 00 0 0 0000 00000000 11 1 1 01 1 02 0 1c 00000abc 0 0 0 00
0040fc83 00 0 0 0000 00000000 12 2 1 03 1 04 0 1f 0000001f 0 0 0 00
00489cc5 00 0 0 0000 00000000 14 2 1 05 1 06 0 07 00000007 0 0 0 00
15000027 00 0 0 0000 00000000 15 1 1 07 1 00 0 00 80001000 0 0 0 00
1c2468a8 00 0 0 0000 00000000 16 3 1 08 1 05 0 1a 12345000 0 0 0 00
// Loads and stores
28bff149 02 0 0 0000 00000000 19 4 1 09 1 0a 0 1c fffffffc 0 0 0 00
2a00418b 00 0 0 0000 00000000 1a 4 1 0b 1 0c 0 10 00000010 0 0 0 00
294009cd 00 0 0 0000 00000000 1d 4 0 00 1 0e 1 0d 00000002 0 0 0 00
29a00041 00 0 0 0000 00000000 1e 4 0 00 1 02 1 01 fffff800 0 0 0 00
// Branches, BLTU and BGEU map onto BLT and BGE
58004085 00 0 0 0000 00000000 1f 5 0 00 1 04 1 05 00000000 0 0 0 00
680080c7 00 0 0 0000 00000000 21 5 0 00 1 06 1 07 00000000 0 0 0 00
6c000109 00 0 0 0000 00000000 22 5 0 00 1 08 1 09 00000000 0 0 0 00
50048c03 00 0 0 0000 00000000 23 5 0 00 0 00 0 03 00000000 0 0 0 00
54010000 00 0 0 0000 00000000 24 5 1 01 0 00 0 00 00000000 0 0 0 00
4c000041 00 0 0 0000 00000000 25 5 1 01 1 02 0 00 00000000 0 0 0 00
// Privileged ops and the level check
04000404 00 0 0 0000 00000000 26 0 1 04 0 00 0 01 00000000 1 0 0 00
04000025 00 0 0 0000 00000000 27 0 1 05 1 05 0 00 00000000 1 1 0 00
040010e6 00 3 0 0000 00000000 28 0 1 06 1 06 1 07 00000000 1 1 1 0e
04000404 00 3 0 0000 00000000 26 0 1 04 0 00 0 01 00000000 1 0 1 0e
04000404 00 3 1 0000 00000000 26 0 1 04 0 00 0 01 00000000 1 0 0 00
04000404 00 3 1 0001 00000000 26 0 1 04 0 00 0 01 00000000 1 0 1 0e
04000404 00 0 1 0000 00000003 26 0 1 04 0 00 0 01 00000000 1 0 1 0e
06483800 00 0 0 0000 00000000 29 0 0 00 0 00 0 0e 00000000 0 0 0 00
06483800 00 3 0 0000 00000000 29 0 0 00 0 00 0 0e 00000000 0 0 1 0e
06488000 00 0 0 0000 00000000 2a 0 0 00 0 00 0 00 00000000 0 0 0 00
06488000 00 1 0 0000 00000000 2a 0 0 00 0 00 0 00 00000000 0 0 1 0e
// Traps
002a0005 00 3 0 0000 00000000 2b 0 0 00 0 00 0 00 00000000 0 0 1 0c
002b0000 00 0 0 0000 00000000 2c 0 0 00 0 00 0 00 00000000 0 0 1 0b
// Dropped and unknown encodings, then the all-zero word
001c0c41 00 0 0 0000 00000000 00 0 0 00 0 02 0 03 00000000 0 0 1 0d
200000a4 00 0 0 0000 00000000 00 0 0 00 0 05 0 00 00000000 0 0 1 0d
000060c0 00 0 0 0000 00000000 00 0 0 00 0 06 0 18 00000000 0 0 1 0d
00000000 3f 0 0 0000 00000000 00 0 0 00 0 00 0 00 00000000 0 0 0 00
ffffffff 04 0 0 0000 00000000 00 0 0 00 0 1f 0 1f 00000000 0 0 1 0d

// ==== flist.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/imm_gen.sv
logic/alu_decode.sv
logic/priv_decode.sv
logic/dispatch_reg.sv
logic/id_stage.sv
sim/id_stage_chk.sv
sim/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_stage
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "Simulation FAILED, no pass line"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_id_stage.sv ====
module tb_id_stage;

  localparam int NUM_FIELDS = 19;
  localparam int MAX_VECS   = 64;
  localparam int MEM_WORDS  = NUM_FIELDS * MAX_VECS;
  localparam int MARGIN     = 30;

  // ------------------------------
  // Column offsets within one vector
  localparam int F_INST     = 0;
  localparam int F_EXC      = 1;
  localparam int F_PLV      = 2;
  localparam int F_FWD_EN   = 3;
  localparam int F_FWD_ADDR = 4;
  localparam int F_FWD_DATA = 5;
  localparam int F_ALUOP    = 6;
  localparam int F_ALUSEL   = 7;
  localparam int F_WEN      = 8;
  localparam int F_WADDR    = 9;
  localparam int F_R1EN     = 10;
  localparam int F_R1ADDR   = 11;
  localparam int F_R2EN     = 12;
  localparam int F_R2ADDR   = 13;
  localparam int F_IMM      = 14;
  localparam int F_CSR_RD   = 15;
  localparam int F_CSR_WR   = 16;
  localparam int F_EX       = 17;
  localparam int F_CAUSE    = 18;

  logic                   clk;
  logic                   rst;
  pipe_pkg::pc_id_t       pc_id;
  isa_pkg::plv_t          crmd_plv;
  pipe_pkg::csr_fwd_t     csr_push_forward;
  pipe_pkg::id_dispatch_t id_dispatch;

  logic [31:0] vec_mem [0:MEM_WORDS-1];
  logic [31:0] lfsr_state;
  int          num_vecs;
  int          check_count;
  int          error_count;
  int          cycle_count = 0;
  int          cycle_limit = MAX_VECS + MARGIN;

  id_stage u_dut (
    .clk              (clk),
    .rst              (rst),
    .pc_id            (pc_id),
    .crmd_plv         (crmd_plv),
    .csr_push_forward (csr_push_forward),
    .id_dispatch      (id_dispatch)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------
  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic load_vectors();
    for (int a = 0; a < MEM_WORDS; a++) begin
      vec_mem[a] = 32'hff00_0000 | a;  // Alusel column above 7 marks no vector
    end
    $readmemh("sim/id_input.dat", vec_mem);
    num_vecs = 0;
    while (num_vecs < MAX_VECS && vec_mem[num_vecs * NUM_FIELDS + F_ALUSEL] <= 32'd7) begin
      num_vecs++;
    end
  endtask

  task automatic drive_vector(input int v);
    int          base;
    logic [31:0] bits;
    base = v * NUM_FIELDS;
    take_bits(30, bits);
    pc_id.pc           = {bits[29:0], 2'b00};
    pc_id.inst         = vec_mem[base + F_INST];
    pc_id.is_exception = vec_mem[base + F_EXC][5:0];
    for (int s = 0; s < isa_pkg::EX_SLOTS; s++) begin
      take_bits(7, bits);
      pc_id.exception_cause[s] = bits[6:0];
    end
    crmd_plv                        = vec_mem[base + F_PLV][1:0];
    csr_push_forward.csr_write_en   = vec_mem[base + F_FWD_EN][0];
    csr_push_forward.csr_write_addr = vec_mem[base + F_FWD_ADDR][13:0];
    csr_push_forward.csr_write_data = vec_mem[base + F_FWD_DATA];
  endtask

  task automatic check_reset_state();
    check_field("reg_write_en", 32'(id_dispatch.reg_write_en), 32'd0);
    check_field("reg1_read_en", 32'(id_dispatch.reg1_read_en), 32'd0);
    check_field("reg2_read_en", 32'(id_dispatch.reg2_read_en), 32'd0);
    check_field("csr_read_en", 32'(id_dispatch.csr_read_en), 32'd0);
    check_field("csr_write_en", 32'(id_dispatch.csr_write_en), 32'd0);
    check_field("is_exception", 32'(id_dispatch.is_exception), 32'd0);
  endtask

  // Driven vector v is expected one cycle later
  task automatic check_vector(input int v);
    int base;
    base = v * NUM_FIELDS;
    check_field("pc", id_dispatch.pc, pc_id.pc);
    check_field("inst", id_dispatch.inst, pc_id.inst);
    check_field("aluop", 32'(id_dispatch.aluop), vec_mem[base + F_ALUOP]);
    check_field("alusel", 32'(id_dispatch.alusel), vec_mem[base + F_ALUSEL]);
    check_field("reg_write_en", 32'(id_dispatch.reg_write_en), vec_mem[base + F_WEN]);
    check_field("reg_write_addr", 32'(id_dispatch.reg_write_addr), vec_mem[base + F_WADDR]);
    check_field("reg1_read_en", 32'(id_dispatch.reg1_read_en), vec_mem[base + F_R1EN]);
    check_field("reg1_read_addr", 32'(id_dispatch.reg1_read_addr), vec_mem[base + F_R1ADDR]);
    check_field("reg2_read_en", 32'(id_dispatch.reg2_read_en), vec_mem[base + F_R2EN]);
    check_field("reg2_read_addr", 32'(id_dispatch.reg2_read_addr), vec_mem[base + F_R2ADDR]);
    check_field("imm", id_dispatch.imm, vec_mem[base + F_IMM]);
    check_field("csr_read_en", 32'(id_dispatch.csr_read_en), vec_mem[base + F_CSR_RD]);
    check_field("csr_write_en", 32'(id_dispatch.csr_write_en), vec_mem[base + F_CSR_WR]);
    check_field("csr_addr", 32'(id_dispatch.csr_addr), 32'(pc_id.inst[23:10]));
    for (int s = 0; s < isa_pkg::EX_SLOTS; s++) begin
      if (s == isa_pkg::EX_SLOT_ID) begin
        check_field($sformatf("is_exception[%0d]", s), 32'(id_dispatch.is_exception[s]),
                    vec_mem[base + F_EX]);
        check_field($sformatf("exception_cause[%0d]", s),
                    32'(id_dispatch.exception_cause[s]), vec_mem[base + F_CAUSE]);
      end else begin
        check_field($sformatf("is_exception[%0d]", s), 32'(id_dispatch.is_exception[s]),
                    32'(pc_id.is_exception[s]));
        check_field($sformatf("exception_cause[%0d]", s),
                    32'(id_dispatch.exception_cause[s]), 32'(pc_id.exception_cause[s]));
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  initial begin
    clk                = 1'b0;
    rst                = 1'b1;
    pc_id              = '0;
    pc_id.inst         = 32'h040010e6;  // CSRXCHG at level 3 sets every enable and slot 2
    pc_id.is_exception = '1;
    crmd_plv           = 2'd3;
    csr_push_forward   = '0;
    lfsr_state         = 32'h3e2a34a7;
    check_count        = 0;
    error_count        = 0;

    load_vectors();
    cycle_limit = num_vecs + MARGIN;
    if (num_vecs == 0) begin
      error_count++;
      $display("No test vectors could be read from sim/id_input.dat");
    end

    repeat (8) @(posedge clk);
    @(negedge clk);
    check_reset_state();
    rst = 1'b0;

    for (int v = 0; v < num_vecs; v++) begin
      drive_vector(v);
      @(negedge clk);
      check_vector(v);
    end

    $display("Vectors: %0d, checks: %0d, errors: %0d", num_vecs, check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim/id_stage_chk.sv ====
module id_stage_chk (
  input logic                   clk,
  input logic                   rst,
  input pipe_pkg::id_dispatch_t id_dispatch
);

  logic any_en;

  assign any_en = id_dispatch.reg_write_en | id_dispatch.reg1_read_en |
                  id_dispatch.reg2_read_en | id_dispatch.csr_read_en |
                  id_dispatch.csr_write_en;

  reset_clears_enables: assert property (@(posedge clk) rst |=> !any_en)
    else $error("Enables still set in the cycle after reset");

  csr_write_has_read: assert property (@(posedge clk) disable iff (rst)
      id_dispatch.csr_write_en |-> id_dispatch.csr_read_en)
    else $error("CSR write enable without CSR read enable");

  // A bubble only for the all-zero word
  nop_raises_decode_ex: assert property (@(posedge clk) disable iff (rst)
      (id_dispatch.aluop == isa_pkg::ALU_NOP && id_dispatch.inst != '0)
      |-> id_dispatch.is_exception[isa_pkg::EX_SLOT_ID])
    else $error("Undecoded instruction without a decode exception");

endmodule

bind dispatch_reg id_stage_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .id_dispatch (id_dispatch)
);

// ==== logic/id_stage.sv ====
module id_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  pipe_pkg::pc_id_t       pc_id,
  input  isa_pkg::plv_t          crmd_plv,
  input  pipe_pkg::csr_fwd_t     csr_push_forward,
  output pipe_pkg::id_dispatch_t id_dispatch
);

  pipe_pkg::dec_ctrl_t alu_ctrl;
  pipe_pkg::dec_ctrl_t priv_ctrl;

  // ------------------------------
  // Decoders
  alu_decode u_alu_decode (
    .inst (pc_id.inst),
    .ctrl (alu_ctrl)
  );

  priv_decode u_priv_decode (
    .inst             (pc_id.inst),
    .crmd_plv         (crmd_plv),
    .csr_push_forward (csr_push_forward),
    .ctrl             (priv_ctrl)
  );

  // ------------------------------
  // Merge and register
  dispatch_reg u_dispatch_reg (
    .clk         (clk),
    .rst         (rst),
    .pc_id       (pc_id),
    .alu_ctrl    (alu_ctrl),
    .priv_ctrl   (priv_ctrl),
    .id_dispatch (id_dispatch)
  );

endmodule

// ==== logic/dispatch_reg.sv ====
module dispatch_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  pipe_pkg::pc_id_t       pc_id,
  input  pipe_pkg::dec_ctrl_t    alu_ctrl,
  input  pipe_pkg::dec_ctrl_t    priv_ctrl,
  output pipe_pkg::id_dispatch_t id_dispatch
);

  pipe_pkg::dec_ctrl_t    sel;
  pipe_pkg::id_dispatch_t nxt;
  logic [31:0]            imm;
  logic                   decoded;

  // ------------------------------
  // Pick the decoder that claimed the word
  always_comb begin
    if (alu_ctrl.hit) begin
      sel = alu_ctrl;
    end else if (priv_ctrl.hit) begin
      sel = priv_ctrl;
    end else begin
      sel                = '0;
      sel.aluop          = isa_pkg::ALU_NOP;
      sel.alusel         = isa_pkg::ALU_SEL_NOP;
      sel.imm_kind       = isa_pkg::IMM_NONE;
      sel.ex_cause       = isa_pkg::EX_NOP;
      sel.reg1_read_addr = pc_id.inst[isa_pkg::RJ_LSB +: isa_pkg::REG_W];
      sel.reg2_read_addr = pc_id.inst[isa_pkg::RK_LSB +: isa_pkg::REG_W];
    end
  end

  imm_gen u_imm_gen (
    .inst     (pc_id.inst),
    .imm_kind (sel.imm_kind),
    .imm      (imm)
  );

  // All-zero word passes as a bubble
  assign decoded = alu_ctrl.hit || priv_ctrl.hit || (pc_id.inst == '0);

  always_comb begin
    nxt.pc             = pc_id.pc;
    nxt.inst           = pc_id.inst;
    nxt.aluop          = sel.aluop;
    nxt.alusel         = sel.alusel;
    nxt.reg_write_en   = sel.reg_write_en;
    nxt.reg_write_addr = sel.reg_write_addr;
    nxt.reg1_read_en   = sel.reg1_read_en;
    nxt.reg1_read_addr = sel.reg1_read_addr;
    nxt.reg2_read_en   = sel.reg2_read_en;
    nxt.reg2_read_addr = sel.reg2_read_addr;
    nxt.imm            = imm;
    nxt.csr_read_en    = sel.csr_read_en;
    nxt.csr_write_en   = sel.csr_write_en;
    nxt.csr_addr       = pc_id.inst[isa_pkg::CSR_LSB +: 14];

    nxt.is_exception    = pc_id.is_exception;
    nxt.exception_cause = pc_id.exception_cause;
    nxt.is_exception[isa_pkg::EX_SLOT_ID]    = decoded ? sel.ex : 1'b1;
    nxt.exception_cause[isa_pkg::EX_SLOT_ID] = decoded ? sel.ex_cause : isa_pkg::EX_INE;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_dispatch <= '0;
    end else begin
      id_dispatch <= nxt;
    end
  end

endmodule

// ==== logic/priv_decode.sv ====
module priv_decode (
  input  isa_pkg::inst_t      inst,
  input  isa_pkg::plv_t       crmd_plv,
  input  pipe_pkg::csr_fwd_t  csr_push_forward,
  output pipe_pkg::dec_ctrl_t ctrl
);

  logic [16:0]        opc17;
  logic [7:0]         opc8;
  logic [21:0]        opc22;
  isa_pkg::reg_addr_t rd;
  isa_pkg::reg_addr_t rj;
  isa_pkg::reg_addr_t rk;
  logic               crmd_fwd;
  isa_pkg::plv_t      cur_plv;
  logic               priv_op;

  assign opc17 = inst[31:isa_pkg::OPC17_LSB];
  assign opc8  = inst[31:isa_pkg::OPC8_LSB];
  assign opc22 = inst[31:isa_pkg::OPC22_LSB];
  assign rd    = inst[isa_pkg::RD_LSB +: isa_pkg::REG_W];
  assign rj    = inst[isa_pkg::RJ_LSB +: isa_pkg::REG_W];
  assign rk    = inst[isa_pkg::RK_LSB +: isa_pkg::REG_W];

  // Level seen by this instruction
  assign crmd_fwd = csr_push_forward.csr_write_en &&
                    (csr_push_forward.csr_write_addr == isa_pkg::CSR_CRMD);
  assign cur_plv  = crmd_fwd ? csr_push_forward.csr_write_data[1:0] : crmd_plv;

  always_comb begin
    ctrl                = '0;
    ctrl.reg1_read_addr = rj;
    ctrl.reg2_read_addr = rk;
    priv_op             = 1'b0;

    if (opc17 == isa_pkg::OPC_BREAK) begin
      ctrl.hit      = 1'b1;
      ctrl.aluop    = isa_pkg::ALU_BREAK;
      ctrl.ex       = 1'b1;
      ctrl.ex_cause = isa_pkg::EX_BRK;
    end else if (opc17 == isa_pkg::OPC_SYSCALL) begin
      ctrl.hit      = 1'b1;
      ctrl.aluop    = isa_pkg::ALU_SYSCALL;
      ctrl.ex       = 1'b1;
      ctrl.ex_cause = isa_pkg::EX_SYS;
    end else if (opc17 == isa_pkg::OPC_IDLE) begin
      ctrl.hit   = 1'b1;
      ctrl.aluop = isa_pkg::ALU_IDLE;
      priv_op    = 1'b1;
    end else if (opc22 == isa_pkg::OPC_ERTN) begin
      ctrl.hit   = 1'b1;
      ctrl.aluop = isa_pkg::ALU_ERTN;
      priv_op    = 1'b1;
    end else if (opc8 == isa_pkg::OPC_CSR) begin
      ctrl.hit            = 1'b1;
      ctrl.reg_write_en   = 1'b1;
      ctrl.reg_write_addr = rd;
      ctrl.csr_read_en    = 1'b1;
      priv_op             = 1'b1;
      case (rj)
        isa_pkg::CSRRD_RJ: ctrl.aluop = isa_pkg::ALU_CSRRD;
        isa_pkg::CSRWR_RJ: begin
          ctrl.aluop          = isa_pkg::ALU_CSRWR;
          ctrl.csr_write_en   = 1'b1;
          ctrl.reg1_read_en   = 1'b1;
          ctrl.reg1_read_addr = rd;
        end
        default: begin  // rj holds the write mask
          ctrl.aluop          = isa_pkg::ALU_CSRXCHG;
          ctrl.csr_write_en   = 1'b1;
          ctrl.reg1_read_en   = 1'b1;
          ctrl.reg1_read_addr = rd;
          ctrl.reg2_read_en   = 1'b1;
          ctrl.reg2_read_addr = rj;
        end
      endcase
    end

    if (priv_op && (cur_plv != isa_pkg::PLV_KERNEL)) begin
      ctrl.ex       = 1'b1;
      ctrl.ex_cause = isa_pkg::EX_IPE;
    end
  end

endmodule

// ==== logic/alu_decode.sv ====
module alu_decode (
  input  isa_pkg::inst_t      inst,
  output pipe_pkg::dec_ctrl_t ctrl
);

  logic [9:0]         opc10;
  logic [16:0]        opc17;
  logic [6:0]         opc7;
  logic [5:0]         opc6;
  isa_pkg::reg_addr_t rd;
  isa_pkg::reg_addr_t rj;
  isa_pkg::reg_addr_t rk;
  isa_pkg::aluop_t    op;

  assign opc10 = inst[31:isa_pkg::OPC10_LSB];
  assign opc17 = inst[31:isa_pkg::OPC17_LSB];
  assign opc7  = inst[31:isa_pkg::OPC7_LSB];
  assign opc6  = inst[31:isa_pkg::OPC6_LSB];
  assign rd    = inst[isa_pkg::RD_LSB +: isa_pkg::REG_W];
  assign rj    = inst[isa_pkg::RJ_LSB +: isa_pkg::REG_W];
  assign rk    = inst[isa_pkg::RK_LSB +: isa_pkg::REG_W];

  // ------------------------------
  // Opcode match over the top fields
  always_comb begin
    op = isa_pkg::ALU_NOP;
    case (opc10)
      isa_pkg::OPC_SLTI:  op = isa_pkg::ALU_SLTI;
      isa_pkg::OPC_SLTUI: op = isa_pkg::ALU_SLTUI;
      isa_pkg::OPC_ADDIW: op = isa_pkg::ALU_ADDIW;
      isa_pkg::OPC_ANDI:  op = isa_pkg::ALU_ANDI;
      isa_pkg::OPC_ORI:   op = isa_pkg::ALU_ORI;
      isa_pkg::OPC_XORI:  op = isa_pkg::ALU_XORI;
      isa_pkg::OPC_LDB:   op = isa_pkg::ALU_LDB;
      isa_pkg::OPC_LDH:   op = isa_pkg::ALU_LDH;
      isa_pkg::OPC_LDW:   op = isa_pkg::ALU_LDW;
      isa_pkg::OPC_LDBU:  op = isa_pkg::ALU_LDBU;
      isa_pkg::OPC_LDHU:  op = isa_pkg::ALU_LDHU;
      isa_pkg::OPC_STB:   op = isa_pkg::ALU_STB;
      isa_pkg::OPC_STH:   op = isa_pkg::ALU_STH;
      isa_pkg::OPC_STW:   op = isa_pkg::ALU_STW;
      default: ;
    endcase
    case (opc17)
      isa_pkg::OPC_ADDW:  op = isa_pkg::ALU_ADDW;
      isa_pkg::OPC_SUBW:  op = isa_pkg::ALU_SUBW;
      isa_pkg::OPC_SLT:   op = isa_pkg::ALU_SLT;
      isa_pkg::OPC_SLTU:  op = isa_pkg::ALU_SLTU;
      isa_pkg::OPC_NOR:   op = isa_pkg::ALU_NOR;
      isa_pkg::OPC_AND:   op = isa_pkg::ALU_AND;
      isa_pkg::OPC_OR:    op = isa_pkg::ALU_OR;
      isa_pkg::OPC_XOR:   op = isa_pkg::ALU_XOR;
      isa_pkg::OPC_SLLW:  op = isa_pkg::ALU_SLLW;
      isa_pkg::OPC_SRLW:  op = isa_pkg::ALU_SRLW;
      isa_pkg::OPC_SRAW:  op = isa_pkg::ALU_SRAW;
      isa_pkg::OPC_SLLIW: op = isa_pkg::ALU_SLLIW;
      isa_pkg::OPC_SRLIW: op = isa_pkg::ALU_SRLIW;
      isa_pkg::OPC_SRAIW: op = isa_pkg::ALU_SRAIW;
      default: ;
    endcase
    case (opc7)
      isa_pkg::OPC_LU12I:     op = isa_pkg::ALU_LU12I;
      isa_pkg::OPC_PCADDU12I: op = isa_pkg::ALU_PCADDU12I;
      default: ;
    endcase
    case (opc6)
      isa_pkg::OPC_BEQ:  op = isa_pkg::ALU_BEQ;
      isa_pkg::OPC_BNE:  op = isa_pkg::ALU_BNE;
      isa_pkg::OPC_BLT:  op = isa_pkg::ALU_BLT;
      isa_pkg::OPC_BGE:  op = isa_pkg::ALU_BGE;
      isa_pkg::OPC_BLTU: op = isa_pkg::ALU_BLT;  // Unsigned compare folded onto signed
      isa_pkg::OPC_BGEU: op = isa_pkg::ALU_BGE;
      isa_pkg::OPC_B:    op = isa_pkg::ALU_B;
      isa_pkg::OPC_BL:   op = isa_pkg::ALU_BL;
      isa_pkg::OPC_JIRL: op = isa_pkg::ALU_JIRL;
      default: ;
    endcase
  end

  // ------------------------------
  // Class, register roles, immediate kind
  always_comb begin
    ctrl                = '0;
    ctrl.hit            = (op != isa_pkg::ALU_NOP);
    ctrl.aluop          = op;
    ctrl.reg1_read_addr = rj;
    ctrl.reg2_read_addr = rk;

    case (op)
      isa_pkg::ALU_NOR, isa_pkg::ALU_AND, isa_pkg::ALU_OR, isa_pkg::ALU_XOR,
      isa_pkg::ALU_ANDI, isa_pkg::ALU_ORI, isa_pkg::ALU_XORI,
      isa_pkg::ALU_LU12I: ctrl.alusel = isa_pkg::ALU_SEL_LOGIC;
      isa_pkg::ALU_SLLW, isa_pkg::ALU_SRLW, isa_pkg::ALU_SRAW, isa_pkg::ALU_SLLIW,
      isa_pkg::ALU_SRLIW, isa_pkg::ALU_SRAIW: ctrl.alusel = isa_pkg::ALU_SEL_SHIFT;
      isa_pkg::ALU_ADDW, isa_pkg::ALU_SUBW, isa_pkg::ALU_SLT, isa_pkg::ALU_SLTU,
      isa_pkg::ALU_SLTI, isa_pkg::ALU_SLTUI, isa_pkg::ALU_ADDIW,
      isa_pkg::ALU_PCADDU12I: ctrl.alusel = isa_pkg::ALU_SEL_ARITHMETIC;
      isa_pkg::ALU_LDB, isa_pkg::ALU_LDH, isa_pkg::ALU_LDW, isa_pkg::ALU_LDBU,
      isa_pkg::ALU_LDHU, isa_pkg::ALU_STB, isa_pkg::ALU_STH,
      isa_pkg::ALU_STW: ctrl.alusel = isa_pkg::ALU_SEL_LOAD_STORE;
      isa_pkg::ALU_BEQ, isa_pkg::ALU_BNE, isa_pkg::ALU_BLT, isa_pkg::ALU_BGE,
      isa_pkg::ALU_B, isa_pkg::ALU_BL,
      isa_pkg::ALU_JIRL: ctrl.alusel = isa_pkg::ALU_SEL_JUMP_BRANCH;
      default: ctrl.alusel = isa_pkg::ALU_SEL_NOP;
    endcase

    case (op)
      isa_pkg::ALU_ADDW, isa_pkg::ALU_SUBW, isa_pkg::ALU_SLT, isa_pkg::ALU_SLTU,
      isa_pkg::ALU_NOR, isa_pkg::ALU_AND, isa_pkg::ALU_OR, isa_pkg::ALU_XOR,
      isa_pkg::ALU_SLLW, isa_pkg::ALU_SRLW, isa_pkg::ALU_SRAW: begin
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = rd;
        ctrl.reg1_read_en   = 1'b1;
        ctrl.reg2_read_en   = 1'b1;
      end
      isa_pkg::ALU_SLTI, isa_pkg::ALU_SLTUI, isa_pkg::ALU_ADDIW, isa_pkg::ALU_LDB,
      isa_pkg::ALU_LDH, isa_pkg::ALU_LDW, isa_pkg::ALU_LDBU, isa_pkg::ALU_LDHU,
      isa_pkg::ALU_ANDI, isa_pkg::ALU_ORI, isa_pkg::ALU_XORI, isa_pkg::ALU_SLLIW,
      isa_pkg::ALU_SRLIW, isa_pkg::ALU_SRAIW, isa_pkg::ALU_LU12I,
      isa_pkg::ALU_PCADDU12I, isa_pkg::ALU_JIRL: begin
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = rd;
        ctrl.reg1_read_en   = 1'b1;
      end
      isa_pkg::ALU_STB, isa_pkg::ALU_STH, isa_pkg::ALU_STW, isa_pkg::ALU_BEQ,
      isa_pkg::ALU_BNE, isa_pkg::ALU_BLT, isa_pkg::ALU_BGE: begin
        ctrl.reg1_read_en   = 1'b1;
        ctrl.reg2_read_en   = 1'b1;
        ctrl.reg2_read_addr = rd;  // Store data or compare operand
      end
      isa_pkg::ALU_BL: begin
        ctrl.reg_write_en   = 1'b1;
        ctrl.reg_write_addr = 5'd1;  // Link register
      end
      default: ;
    endcase

    case (op)
      isa_pkg::ALU_ANDI, isa_pkg::ALU_ORI,
      isa_pkg::ALU_XORI: ctrl.imm_kind = isa_pkg::IMM_UI12;
      isa_pkg::ALU_SLLIW, isa_pkg::ALU_SRLIW,
      isa_pkg::ALU_SRAIW: ctrl.imm_kind = isa_pkg::IMM_UI5;
      isa_pkg::ALU_LU12I, isa_pkg::ALU_PCADDU12I: ctrl.imm_kind = isa_pkg::IMM_SI20_HI;
      isa_pkg::ALU_SLTI, isa_pkg::ALU_SLTUI, isa_pkg::ALU_ADDIW, isa_pkg::ALU_LDB,
      isa_pkg::ALU_LDH, isa_pkg::ALU_LDW, isa_pkg::ALU_LDBU, isa_pkg::ALU_LDHU,
      isa_pkg::ALU_STB, isa_pkg::ALU_STH,
      isa_pkg::ALU_STW: ctrl.imm_kind = isa_pkg::IMM_SI12;
      default: ctrl.imm_kind = isa_pkg::IMM_NONE;
    endcase

    if (op == isa_pkg::ALU_LU12I) begin
      ctrl.reg1_read_addr = '0;  // Adds to r0
    end
  end

endmodule

// ==== logic/imm_gen.sv ====
module imm_gen (
  input  isa_pkg::inst_t     inst,
  input  isa_pkg::imm_kind_t imm_kind,
  output logic [31:0]        imm
);

  logic [11:0] i12;
  logic [4:0]  ui5;
  logic [19:0] si20;

  assign i12  = inst[isa_pkg::I12_LSB +: 12];
  assign ui5  = inst[isa_pkg::RK_LSB +: 5];
  assign si20 = inst[isa_pkg::SI20_LSB +: 20];

  always_comb begin
    case (imm_kind)
      isa_pkg::IMM_SI12:    imm = {{20{i12[11]}}, i12};
      isa_pkg::IMM_UI12:    imm = {20'b0, i12};
      isa_pkg::IMM_UI5:     imm = {27'b0, ui5};  // Shift amount
      isa_pkg::IMM_SI20_HI: imm = {si20, 12'b0};
      default:              imm = '0;
    endcase
  end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

  // ------------------------------
  // Fetch to decode
  typedef struct packed {
    logic [31:0]                                      pc;
    isa_pkg::inst_t                                   inst;
    logic [isa_pkg::EX_SLOTS-1:0]                     is_exception;
    isa_pkg::ex_cause_t [isa_pkg::EX_SLOTS-1:0]       exception_cause;
  } pc_id_t;

  // CSR write still in flight downstream
  typedef struct packed {
    logic                csr_write_en;
    isa_pkg::csr_addr_t  csr_write_addr;
    logic [31:0]         csr_write_data;
  } csr_fwd_t;

  // ------------------------------
  // Decoder result
  typedef struct packed {
    logic                hit;
    isa_pkg::aluop_t     aluop;
    isa_pkg::alusel_t    alusel;
    logic                reg_write_en;
    isa_pkg::reg_addr_t  reg_write_addr;
    logic                reg1_read_en;
    isa_pkg::reg_addr_t  reg1_read_addr;
    logic                reg2_read_en;
    isa_pkg::reg_addr_t  reg2_read_addr;
    isa_pkg::imm_kind_t  imm_kind;
    logic                csr_read_en;
    logic                csr_write_en;
    logic                ex;
    isa_pkg::ex_cause_t  ex_cause;
  } dec_ctrl_t;

  // ------------------------------
  // Decode to dispatch
  typedef struct packed {
    logic [31:0]                                      pc;
    isa_pkg::inst_t                                   inst;
    isa_pkg::aluop_t                                  aluop;
    isa_pkg::alusel_t                                 alusel;
    logic                                             reg_write_en;
    isa_pkg::reg_addr_t                               reg_write_addr;
    logic                                             reg1_read_en;
    isa_pkg::reg_addr_t                               reg1_read_addr;
    logic                                             reg2_read_en;
    isa_pkg::reg_addr_t                               reg2_read_addr;
    logic [31:0]                                      imm;
    logic                                             csr_read_en;
    logic                                             csr_write_en;
    isa_pkg::csr_addr_t                               csr_addr;
    logic [isa_pkg::EX_SLOTS-1:0]                     is_exception;
    isa_pkg::ex_cause_t [isa_pkg::EX_SLOTS-1:0]       exception_cause;
  } id_dispatch_t;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [13:0] csr_addr_t;
  typedef logic [1:0]  plv_t;

  localparam plv_t      PLV_KERNEL = 2'd0;
  localparam csr_addr_t CSR_CRMD   = 14'h0000;

  // ------------------------------
  // Field positions
  localparam int OPC10_LSB = 22;
  localparam int OPC17_LSB = 15;
  localparam int OPC7_LSB  = 25;
  localparam int OPC8_LSB  = 24;
  localparam int OPC6_LSB  = 26;
  localparam int OPC22_LSB = 10;
  localparam int REG_W     = 5;
  localparam int RD_LSB    = 0;
  localparam int RJ_LSB    = 5;
  localparam int RK_LSB    = 10;  // Shared with ui5
  localparam int I12_LSB   = 10;
  localparam int CSR_LSB   = 10;
  localparam int SI20_LSB  = 5;

  // ------------------------------
  // ALU operation and class
  typedef enum logic [7:0] {
    ALU_NOP = 8'h00,
    ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLLW, ALU_SRLW, ALU_SRAW,
    ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_ANDI, ALU_ORI, ALU_XORI,
    ALU_SLLIW, ALU_SRLIW, ALU_SRAIW, ALU_LU12I, ALU_PCADDU12I,
    ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_STB, ALU_STH, ALU_STW,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_B, ALU_BL, ALU_JIRL,
    ALU_CSRRD, ALU_CSRWR, ALU_CSRXCHG, ALU_ERTN, ALU_IDLE, ALU_BREAK, ALU_SYSCALL
  } aluop_t;

  typedef enum logic [2:0] {
    ALU_SEL_NOP = 3'd0,
    ALU_SEL_LOGIC, ALU_SEL_SHIFT, ALU_SEL_ARITHMETIC, ALU_SEL_LOAD_STORE,
    ALU_SEL_JUMP_BRANCH
  } alusel_t;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_SI12, IMM_UI12, IMM_UI5, IMM_SI20_HI
  } imm_kind_t;

  // ------------------------------
  // Exceptions
  typedef logic [6:0] ex_cause_t;

  localparam ex_cause_t EX_NOP = 7'h00;
  localparam ex_cause_t EX_SYS = 7'h0b;
  localparam ex_cause_t EX_BRK = 7'h0c;
  localparam ex_cause_t EX_INE = 7'h0d;
  localparam ex_cause_t EX_IPE = 7'h0e;

  localparam int EX_SLOTS   = 6;
  localparam int EX_SLOT_ID = 2;  // Decode owns this slot

  // ------------------------------
  // Opcodes by top-field width
  localparam logic [9:0] OPC_SLTI  = 10'h008;
  localparam logic [9:0] OPC_SLTUI = 10'h009;
  localparam logic [9:0] OPC_ADDIW = 10'h00a;
  localparam logic [9:0] OPC_ANDI  = 10'h00d;
  localparam logic [9:0] OPC_ORI   = 10'h00e;
  localparam logic [9:0] OPC_XORI  = 10'h00f;
  localparam logic [9:0] OPC_LDB   = 10'h0a0;
  localparam logic [9:0] OPC_LDH   = 10'h0a1;
  localparam logic [9:0] OPC_LDW   = 10'h0a2;
  localparam logic [9:0] OPC_STB   = 10'h0a4;
  localparam logic [9:0] OPC_STH   = 10'h0a5;
  localparam logic [9:0] OPC_STW   = 10'h0a6;
  localparam logic [9:0] OPC_LDBU  = 10'h0a8;
  localparam logic [9:0] OPC_LDHU  = 10'h0a9;

  localparam logic [16:0] OPC_ADDW    = 17'h00020;
  localparam logic [16:0] OPC_SUBW    = 17'h00022;
  localparam logic [16:0] OPC_SLT     = 17'h00024;
  localparam logic [16:0] OPC_SLTU    = 17'h00025;
  localparam logic [16:0] OPC_NOR     = 17'h00028;
  localparam logic [16:0] OPC_AND     = 17'h00029;
  localparam logic [16:0] OPC_OR      = 17'h0002a;
  localparam logic [16:0] OPC_XOR     = 17'h0002b;
  localparam logic [16:0] OPC_SLLW    = 17'h0002e;
  localparam logic [16:0] OPC_SRLW    = 17'h0002f;
  localparam logic [16:0] OPC_SRAW    = 17'h00030;
  localparam logic [16:0] OPC_BREAK   = 17'h00054;
  localparam logic [16:0] OPC_SYSCALL = 17'h00056;
  localparam logic [16:0] OPC_SLLIW   = 17'h00081;
  localparam logic [16:0] OPC_SRLIW   = 17'h00089;
  localparam logic [16:0] OPC_SRAIW   = 17'h00091;
  localparam logic [16:0] OPC_IDLE    = 17'h00c91;

  localparam logic [6:0] OPC_LU12I     = 7'h0a;
  localparam logic [6:0] OPC_PCADDU12I = 7'h0e;

  localparam logic [7:0] OPC_CSR = 8'h04;

  localparam logic [5:0] OPC_JIRL = 6'h13;
  localparam logic [5:0] OPC_B    = 6'h14;
  localparam logic [5:0] OPC_BL   = 6'h15;
  localparam logic [5:0] OPC_BEQ  = 6'h16;
  localparam logic [5:0] OPC_BNE  = 6'h17;
  localparam logic [5:0] OPC_BLT  = 6'h18;
  localparam logic [5:0] OPC_BGE  = 6'h19;
  localparam logic [5:0] OPC_BLTU = 6'h1a;
  localparam logic [5:0] OPC_BGEU = 6'h1b;

  localparam logic [21:0] OPC_ERTN = 22'h01920e;

  localparam reg_addr_t CSRRD_RJ = 5'd0;  // CSR group split on rj
  localparam reg_addr_t CSRWR_RJ = 5'd1;

endpackage
